// ==== common/upd_sound_pkg.sv ====
// shared types, APB register map and tone vector constants
// for the sound section
`default_nettype none

package upd_sound_pkg;

  //////////////////////////////
  // widths with a meaning
  //////////////////////////////

  typedef logic [1:0] reg_addr_t;  // APB word address
  typedef logic [7:0] reg_data_t;  // APB data byte
  typedef logic [7:0] tone_cnt_t;  // N and NC
  typedef logic [2:0] nuc_t;       // reload counter

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam reg_addr_t ADDR_MD   = 2'd0;  // mode
  localparam reg_addr_t ADDR_N    = 2'd1;  // tone reload value
  localparam reg_addr_t ADDR_DA   = 2'd2;  // sample, latches DAC
  localparam reg_addr_t ADDR_STAT = 2'd3;  // signs on write, status on read

  localparam int MD_TONE_IE_BIT = 1;  // tone interrupt enable in MD

  // bit positions in an ADDR_STAT write
  localparam int STAT_CLR_BIT = 1;  // clear pending
  localparam int STAT_SS_BIT  = 6;  // sample sign
  localparam int STAT_TS_BIT  = 7;  // tone sign

  //////////////////////////////
  // interrupt vectors
  //////////////////////////////

  localparam reg_data_t VEC_TONE_BASE = 8'h20;

endpackage

`default_nettype wire

// ==== rtl/sound_regs.sv ====
// APB slave with mode, tone reload, sign and sample registers
// plus status read mux and the DAC load / interrupt clear strobes
`timescale 1ns/1ps
`default_nettype none

module sound_regs (
  input  wire                      CLK,
  input  wire                      reset,
  input  upd_sound_pkg::reg_addr_t paddr,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  upd_sound_pkg::reg_data_t pwdata,
  output upd_sound_pkg::reg_data_t prdata,
  output logic                     pready,
  input  upd_sound_pkg::reg_data_t irq_vec,
  input  wire                      pending,
  output upd_sound_pkg::tone_cnt_t n_val,
  output logic                     tone_ie,
  output logic                     irq_clear,
  output upd_sound_pkg::reg_data_t sample,
  output logic                     tone_sign,
  output logic                     sample_sign,
  output logic                     da_load
);
  import upd_sound_pkg::*;

  reg_data_t md;      // mode register
  tone_cnt_t n_reg;   // tone reload N
  reg_data_t da_reg;  // last sample written
  logic      wr_en;

  assign wr_en  = psel & penable & pwrite;  // access phase write
  assign pready = 1'b1;                     // zero wait states

  //////////////////////////////
  // control registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      md          <= '0;
      n_reg       <= '0;
      tone_sign   <= 1'b0;
      sample_sign <= 1'b0;
    end else if (wr_en) begin
      case (paddr)
        ADDR_MD: md <= pwdata;
        ADDR_N:  n_reg <= pwdata;
        ADDR_STAT: begin
          tone_sign   <= pwdata[STAT_TS_BIT];
          sample_sign <= pwdata[STAT_SS_BIT];
        end
        default: ;  // sample handled below
      endcase
    end
  end

  // sample byte
  always_ff @(posedge CLK) begin
    if (wr_en && (paddr == ADDR_DA)) begin
      da_reg <= pwdata;
    end
  end

  //////////////////////////////
  // strobes, one clock wide
  //////////////////////////////

  // registered so the DAC sees the new sample and signs
  always_ff @(posedge CLK) begin
    if (reset) begin
      da_load   <= 1'b0;
      irq_clear <= 1'b0;
    end else begin
      da_load   <= wr_en & (paddr == ADDR_DA);
      irq_clear <= wr_en & (paddr == ADDR_STAT) & pwdata[STAT_CLR_BIT];
    end
  end

  assign n_val   = n_reg;
  assign sample  = da_reg;
  assign tone_ie = md[MD_TONE_IE_BIT];

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    case (paddr)
      ADDR_MD:   prdata = md;
      ADDR_N:    prdata = n_reg;
      ADDR_DA:   prdata = da_reg;
      ADDR_STAT: prdata = {irq_vec[7:2], pending, irq_vec[0]};  // vec[1:0] is 0
      default:   prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== tone/tone_counter.sv ====
// tone tick divider, NC down-counter and NUC reload counter
`timescale 1ns/1ps
`default_nettype none

module tone_counter #(
  parameter int TICK_DIV = 8
) (
  input  wire                      CLK,
  input  wire                      reset,
  input  upd_sound_pkg::tone_cnt_t n_val,
  output logic                     tick,
  output logic                     nc_reload_d,
  output upd_sound_pkg::nuc_t      nuc
);
  import upd_sound_pkg::*;

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  tone_cnt_t        nc;         // down-counter
  logic             nc_eq_01;   // reload condition

  //////////////////////////////
  // tick divider
  //////////////////////////////

  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge CLK) begin
    if (reset || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // NC and NUC
  //////////////////////////////

  assign nc_eq_01 = (nc == 8'd1);

  // reload at one, zero wraps through 0xFF
  always_ff @(posedge CLK) begin
    if (reset) begin
      nc <= '0;
    end else if (tick) begin
      if (nc_eq_01)
        nc <= n_val;
      else
        nc <= nc - 1'b1;
    end
  end

  // NUC steps on the tick after a reload
  always_ff @(posedge CLK) begin
    if (reset) begin
      nc_reload_d <= 1'b0;
      nuc         <= '0;
    end else if (tick) begin
      nc_reload_d <= nc_eq_01;
      if (nc_reload_d)
        nuc <= nuc + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tone/tone_irq.sv ====
// tone interrupt: N range decode, falling edge trigger, pending flag
// and vector
`timescale 1ns/1ps
`default_nettype none

module tone_irq (
  input  wire                      CLK,
  input  wire                      reset,
  input  upd_sound_pkg::tone_cnt_t n_val,
  input  wire                      tick,
  input  wire                      nc_reload_d,
  input  upd_sound_pkg::nuc_t      nuc,
  input  wire                      tone_ie,
  input  wire                      irq_clear,
  output logic                     pending,
  output upd_sound_pkg::reg_data_t irq_vec
);
  import upd_sound_pkg::*;

  logic cond;     // selected trigger source
  logic cond_d;   // cond at previous tick
  logic trig;     // falling edge seen
  reg_data_t vec_ofs;

  // source and vector offset follow the range of N
  always_comb begin
    if (n_val < 8'h08) begin
      cond    = 1'b0;  // never fires
      vec_ofs = 8'h00;
    end else if (n_val < 8'h10) begin
      cond    = nuc[2];
      vec_ofs = 8'h00;
    end else if (n_val < 8'h20) begin
      cond    = nuc[1];
      vec_ofs = 8'h04;
    end else if (n_val < 8'h40) begin
      cond    = nuc[0];
      vec_ofs = 8'h08;
    end else begin
      cond    = nc_reload_d;
      vec_ofs = 8'h0C;
    end
  end

  assign irq_vec = VEC_TONE_BASE | vec_ofs;

  //////////////////////////////
  // edge detect and pending
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      cond_d  <= 1'b0;
      trig    <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (tick) begin
        cond_d <= cond;
        trig   <= cond_d & ~cond;  // negedge of cond
      end
      if (irq_clear)
        pending <= 1'b0;
      else if (tick && trig && tone_ie)
        pending <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dac_output.sv ====
// DAC latch with sign driven sample inversion
`timescale 1ns/1ps
`default_nettype none

module dac_output (
  input  wire                      CLK,
  input  wire                      reset,
  input  wire                      da_load,
  input  upd_sound_pkg::reg_data_t sample,
  input  wire                      tone_sign,
  input  wire                      sample_sign,
  output logic                     pcm_neg,
  output upd_sound_pkg::reg_data_t pcm_out
);
  import upd_sound_pkg::*;

  logic      da_inv;  // tone sign differs from sample sign
  logic      da_neg;  // latched sample sign
  reg_data_t da_smp;  // latched sample

  //////////////////////////////
  // DA latch
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      da_inv <= 1'b0;
      da_neg <= 1'b0;
      da_smp <= '0;
    end else if (da_load) begin
      da_inv <= tone_sign ^ sample_sign;
      da_neg <= sample_sign;
      da_smp <= sample;
    end
  end

  assign pcm_neg = da_neg;
  assign pcm_out = da_inv ? ~da_smp : da_smp;  // ones complement on mismatch

endmodule

`default_nettype wire

// ==== rtl/upd_sound_top.sv ====
// sound section top level
// APB register block, tone counter, tone interrupt and DAC latch
`timescale 1ns/1ps
`default_nettype none

module upd_sound_top #(
  parameter int TICK_DIV = 8
) (
  input  wire                      CLK,
  input  wire                      reset,
  input  upd_sound_pkg::reg_addr_t paddr,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  upd_sound_pkg::reg_data_t pwdata,
  output upd_sound_pkg::reg_data_t prdata,
  output logic                     pready,
  output logic                     irq,
  output logic                     pcm_neg,
  output upd_sound_pkg::reg_data_t pcm_out
);
  import upd_sound_pkg::*;

  tone_cnt_t n_val;
  logic      tone_ie;
  logic      irq_clear;
  reg_data_t sample;
  logic      tone_sign;
  logic      sample_sign;
  logic      da_load;
  logic      tick;
  logic      nc_reload_d;
  nuc_t      nuc;
  reg_data_t irq_vec;
  logic      pending;

  assign irq = pending;  // single interrupt source

  sound_regs u_regs (
    .CLK(CLK), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .irq_vec(irq_vec), .pending(pending),
    .n_val(n_val), .tone_ie(tone_ie), .irq_clear(irq_clear),
    .sample(sample), .tone_sign(tone_sign), .sample_sign(sample_sign),
    .da_load(da_load)
  );

  tone_counter #(.TICK_DIV(TICK_DIV)) u_tone_cnt (
    .CLK(CLK), .reset(reset), .n_val(n_val),
    .tick(tick), .nc_reload_d(nc_reload_d), .nuc(nuc)
  );

  tone_irq u_tone_irq (
    .CLK(CLK), .reset(reset), .n_val(n_val), .tick(tick),
    .nc_reload_d(nc_reload_d), .nuc(nuc), .tone_ie(tone_ie),
    .irq_clear(irq_clear), .pending(pending), .irq_vec(irq_vec)
  );

  dac_output u_dac (
    .CLK(CLK), .reset(reset), .da_load(da_load), .sample(sample),
    .tone_sign(tone_sign), .sample_sign(sample_sign),
    .pcm_neg(pcm_neg), .pcm_out(pcm_out)
  );

endmodule

`default_nettype wire

// ==== test/upd_sound_chk.sv ====
// assertions on APB ready, tone interrupt enable and DAC update
`timescale 1ns/1ps
`default_nettype none

module upd_sound_chk (
  input wire                      CLK,
  input wire                      reset,
  input wire                      pready,
  input wire                      irq,
  input wire                      tone_ie,
  input wire                      da_load,
  input upd_sound_pkg::reg_data_t pcm_out
);

  a_pready_high: assert property (@(posedge CLK) disable iff (reset) pready)
    else $error("pready dropped low");

  // pending only sets while the enable is sampled high
  a_irq_needs_ie: assert property (@(posedge CLK) disable iff (reset)
    $rose(irq) |-> $past(tone_ie))
    else $error("irq rose with tone interrupt disabled");

  a_pcm_on_load: assert property (@(posedge CLK) disable iff (reset)
    (pcm_out != $past(pcm_out)) |-> $past(da_load))
    else $error("pcm_out changed without a DAC load");

endmodule

bind upd_sound_top upd_sound_chk u_chk (
  .CLK(CLK), .reset(reset), .pready(pready), .irq(irq),
  .tone_ie(tone_ie), .da_load(da_load), .pcm_out(pcm_out)
);

`default_nettype wire

// ==== test/upd_sound_tb.sv ====
// testbench for the sound section
// APB tasks, reference model, register, DAC and tone interrupt tests
`timescale 1ns/1ps
`default_nettype none

module upd_sound_tb;
  import upd_sound_pkg::*;

  localparam int TICK_DIV = 8;

  logic      CLK;
  logic      reset;
  reg_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  reg_data_t pwdata;
  reg_data_t prdata;
  logic      pready;
  logic      irq;
  logic      pcm_neg;
  reg_data_t pcm_out;

  int        error_count;
  int        test_errors;
  int        tests_failed;
  reg_data_t rd;
  reg_data_t smp;
  tone_cnt_t n;
  logic      ts;
  logic      ss;
  tone_cnt_t range_n [3] = '{8'h0A, 8'h15, 8'h30};

  upd_sound_top #(.TICK_DIV(TICK_DIV)) dut (
    .CLK(CLK), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .irq(irq), .pcm_neg(pcm_neg), .pcm_out(pcm_out)
  );

  always #50 CLK = ~CLK;  // 100 ns period

  //////////////////////////////
  // reference model
  //////////////////////////////

  // ones complement when tone sign and sample sign differ
  function automatic reg_data_t expected_pcm(reg_data_t s, logic t_sgn, logic s_sgn);
    return (t_sgn != s_sgn) ? ~s : s;
  endfunction

  // vector by range of N, pending flag in bit 1
  function automatic reg_data_t expected_stat(tone_cnt_t nv, logic pend);
    reg_data_t v;
    if (nv >= 8'h40)
      v = VEC_TONE_BASE + 8'h0C;
    else if (nv >= 8'h20)
      v = VEC_TONE_BASE + 8'h08;
    else if (nv >= 8'h10)
      v = VEC_TONE_BASE + 8'h04;
    else
      v = VEC_TONE_BASE;
    return v | {6'd0, pend, 1'b0};
  endfunction

  // NC can need 256 ticks to reach its first reload
  function automatic int irq_limit(tone_cnt_t nv);
    return ((int'(nv) + 2) * 16 + 256) * TICK_DIV;
  endfunction

  task automatic compare_value(input string name, input reg_data_t exp, input reg_data_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (error_count != test_errors) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - test_errors);
    end else begin
      $display("test %s: ok", name);
    end
    test_errors = error_count;
  endtask

  //////////////////////////////
  // APB and interrupt tasks
  //////////////////////////////

  task automatic apb_write(input reg_addr_t a, input reg_data_t d);
    @(negedge CLK);
    paddr   = a;
    pwdata  = d;
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    @(negedge CLK);
    penable = 1'b1;  // no wait states, write lands on next edge
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input reg_addr_t a, output reg_data_t d);
    @(negedge CLK);
    paddr   = a;
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    @(negedge CLK);
    penable = 1'b1;
    #25 d = prdata;  // mid access, away from both edges
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_irq(input logic level, input int limit, input string name);
    int cnt;
    cnt = 0;
    while (irq !== level && cnt < limit) begin
      @(negedge CLK);
      cnt++;
    end
    if (irq !== level) begin
      $display("%s: irq did not reach %0b within %0d clocks", name, level, limit);
      error_count++;
    end
  endtask

  task automatic expect_quiet(input int limit, input string name);
    for (int cnt = 0; cnt < limit; cnt++) begin
      @(negedge CLK);
      if (irq !== 1'b0) begin
        $display("%s: irq went high although no interrupt may fire", name);
        error_count++;
        break;
      end
    end
  endtask

  // new N with interrupt off, let the edge detector settle, clear, enable
  task automatic arm_tone(input tone_cnt_t nv, input logic ie);
    apb_write(ADDR_MD, 8'h00);
    apb_write(ADDR_N, nv);
    repeat (3 * TICK_DIV) @(negedge CLK);
    apb_write(ADDR_STAT, 8'h02);
    apb_write(ADDR_MD, 8'(ie) << MD_TONE_IE_BIT);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hff85));
    CLK          = 1'b0;
    reset        = 1'b1;
    paddr        = ADDR_MD;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    error_count  = 0;
    test_errors  = 0;
    tests_failed = 0;
    repeat (5) @(negedge CLK);
    reset = 1'b0;

    compare_value("reset irq", 8'h00, {7'd0, irq});
    compare_value("reset pcm_neg", 8'h00, {7'd0, pcm_neg});
    compare_value("reset pcm_out", 8'h00, pcm_out);
    compare_value("reset pready", 8'h01, {7'd0, pready});
    apb_read(ADDR_MD, rd);
    compare_value("reset MD", 8'h00, rd);
    apb_read(ADDR_N, rd);
    compare_value("reset N", 8'h00, rd);
    end_test("reset state");

    for (int i = 0; i < 4; i++) begin
      smp = 8'($urandom);
      n   = 8'($urandom);
      apb_write(ADDR_MD, smp);
      apb_write(ADDR_N, n);
      apb_read(ADDR_MD, rd);
      compare_value("MD readback", smp, rd);
      apb_read(ADDR_N, rd);
      compare_value("N readback", n, rd);
    end
    apb_write(ADDR_MD, 8'h00);
    end_test("register readback");

    for (int k = 0; k < 8; k++) begin
      smp = 8'($urandom);
      ts  = k[1];
      ss  = k[0];
      apb_write(ADDR_STAT, {ts, ss, 6'd0});
      apb_write(ADDR_DA, smp);
      @(negedge CLK);  // latch is one clock behind the write
      compare_value("DAC pcm_neg", {7'd0, ss}, {7'd0, pcm_neg});
      compare_value("DAC pcm_out", expected_pcm(smp, ts, ss), pcm_out);
    end
    end_test("DAC rule");

    n = 8'h40 + 8'($urandom_range(191));
    arm_tone(n, 1'b1);
    wait_irq(1'b1, irq_limit(n), "tone irq");
    apb_read(ADDR_STAT, rd);
    compare_value("tone status", expected_stat(n, 1'b1), rd);
    apb_write(ADDR_STAT, 8'h02);
    wait_irq(1'b0, 4, "tone clear");
    wait_irq(1'b1, irq_limit(n), "tone irq again");
    end_test("tone interrupt");

    for (int i = 0; i < 3; i++) begin
      arm_tone(range_n[i], 1'b1);
      wait_irq(1'b1, irq_limit(range_n[i]), "range irq");
      apb_read(ADDR_STAT, rd);
      compare_value("range vector", expected_stat(range_n[i], 1'b1), rd);
    end
    end_test("vector by range");

    n = 8'($urandom_range(7));
    arm_tone(n, 1'b1);
    expect_quiet(irq_limit(n), "small N");
    n = 8'h40;
    arm_tone(n, 1'b0);
    expect_quiet(irq_limit(n), "interrupt disabled");
    end_test("no interrupt");

    $display("6 tests run, %0d failed, %0d errors", tests_failed, error_count);
    if (error_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/upd_sound_pkg.sv
rtl/sound_regs.sv
tone/tone_counter.sv
tone/tone_irq.sv
rtl/dac_output.sv
rtl/upd_sound_top.sv
test/upd_sound_chk.sv
test/upd_sound_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sound section testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module upd_sound_tb -f flist.f || exit 1
out=$(./obj_dir/Vupd_sound_tb)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
